// ==== logic/krfec_defines.svh ====
// register map and sizing of the KR FEC control block
// only 0xB2 to 0xB4 of the 0xB0..0xBF window are decoded

`ifndef KRFEC_DEFINES_SVH
`define KRFEC_DEFINES_SVH

// ********************************************************************
// register addresses, one byte each
// ********************************************************************
`define KRFEC_ADDR_STATUS  8'hB2   // fec control
`define KRFEC_ADDR_CRRBLKS 8'hB3   // corrected blocks, read clears
`define KRFEC_ADDR_UNCBLKS 8'hB4   // uncorrected blocks, read clears

// signok_en, fast_search_en and dv_start set out of reset
`define KRFEC_CTRL_RESET 12'h580

// ********************************************************************
// sizing
// ********************************************************************
`define KRFEC_CNT_W       32   // block counter width, equal to the bus width
`define KRFEC_SYNC_STAGES 2    // flops per synchronizer chain
`define KRFEC_ACK_BITS    10   // width of the write_en / write_en_ack handshake

`endif

// ==== logic/krfec_pkg.sv ====
// shared types of the KR FEC control block
// field order of fec_ctrl_t follows the bit layout of register 0xB2

`include "krfec_defines.svh"

package krfec_pkg;

  // memory mapped request, read and write are single cycle strobes
  typedef struct packed {
    logic [7:0]  address;
    logic        read;
    logic        write;
    logic [31:0] writedata;
  } avmm_req_t;

  // control word, msb first so bit 11 is tx_err_ins
  typedef struct packed {
    logic       tx_err_ins;        // self clearing
    logic       rx_dv_start;
    logic       rx_blksync_cor_en;
    logic       rx_fast_search_en;
    logic       rx_signok_en;
    logic       tx_enc_query;
    logic [3:0] tx_burst_err_len;
    logic       tx_burst_err;
    logic       tx_trans_err;
  } fec_ctrl_t;

  typedef struct packed {
    logic [`KRFEC_CNT_W-1:0] corr_blks;
    logic [`KRFEC_CNT_W-1:0] uncr_blks;
  } fec_counts_t;

  typedef struct packed {
    logic clear_counters;   // clears both counters
    logic clr_corr_blks;
    logic clr_uncr_blks;
  } fec_clears_t;

endpackage

// ==== logic/fec_block_counter.sv ====
// saturating block event counter in rx_clk
// clear wins over an event in the same cycle

`include "krfec_defines.svh"

module fec_block_counter (
  input  logic                    rx_clk,
  input  logic                    reset,
  input  logic                    event_in,   // one cycle pulse per block
  input  logic                    clear,      // synchronous clear
  output logic [`KRFEC_CNT_W-1:0] count
);

  logic saturated;

  assign saturated = &count;                  // stick at all ones

  always_ff @(posedge rx_clk or posedge reset) begin
    if (reset) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;
    end else if (event_in && !saturated) begin
      count <= count + 1'b1;
    end
  end

  // ********************************************************************
  // checks
  // ********************************************************************
  // only a clear can take the count down
  a_no_decrease : assert property (@(posedge rx_clk) disable iff (reset)
    !clear |=> (count >= $past(count)));

endmodule

// ==== logic/krfec_csr.sv ====
// register file, no wait states, readdata valid one clk after the address
// counts arrive from rx_clk and are only sampled under the write_en handshake
// ctrl leaves unsynchronized, consumers treat it as static

`include "krfec_defines.svh"

module krfec_csr import krfec_pkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  input  avmm_req_t                  req,
  input  fec_counts_t                counts,        // held copy from rx_clk side
  input  logic [`KRFEC_ACK_BITS-1:0] write_en_ack,
  output logic [31:0]                readdata,
  output fec_ctrl_t                  ctrl,
  output fec_clears_t                clears,
  output logic [`KRFEC_ACK_BITS-1:0] write_en
);

  fec_ctrl_t   ctrl_q;
  fec_counts_t snap_q;                    // counts as last handed over
  logic [3:0]  clr_ctr_sr;                // master clear shifter
  logic [3:0]  clr_crr_sr;
  logic [3:0]  clr_unc_sr;
  logic [`KRFEC_SYNC_STAGES-1:0][`KRFEC_ACK_BITS-1:0] ack_sync;
  logic [`KRFEC_ACK_BITS-1:0] ack_s;

  // ********************************************************************
  // address decode, control register and clear shifters
  // ********************************************************************
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ctrl_q     <= `KRFEC_CTRL_RESET;
      readdata   <= '0;
      clr_ctr_sr <= '0;
      clr_crr_sr <= '0;
      clr_unc_sr <= '0;
    end else begin
      readdata   <= '0;                   // unmapped addresses read zero
      clr_ctr_sr <= {1'b0, clr_ctr_sr[3:1]};
      clr_crr_sr <= {1'b0, clr_crr_sr[3:1]};
      clr_unc_sr <= {1'b0, clr_unc_sr[3:1]};
      if (ctrl_q.tx_err_ins)
        ctrl_q.tx_err_ins <= 1'b0;        // one cycle error insert
      case (req.address)
        `KRFEC_ADDR_STATUS: begin
          readdata <= {20'd0, ctrl_q};
          if (req.write)
            ctrl_q <= req.writedata[11:0];
        end
        `KRFEC_ADDR_CRRBLKS: begin
          readdata <= snap_q.corr_blks;
          if (req.read) begin
            clr_ctr_sr[3:2] <= 2'b11;     // two cycle pulse, three cycles out
            clr_crr_sr[3:2] <= 2'b11;
          end
        end
        `KRFEC_ADDR_UNCBLKS: begin
          readdata <= snap_q.uncr_blks;
          if (req.read) begin
            clr_ctr_sr[3:2] <= 2'b11;
            clr_unc_sr[3:2] <= 2'b11;
          end
        end
        default: ;
      endcase
    end
  end

  assign ctrl                  = ctrl_q;
  assign clears.clear_counters = clr_ctr_sr[0];
  assign clears.clr_corr_blks  = clr_crr_sr[0];
  assign clears.clr_uncr_blks  = clr_unc_sr[0];

  // ********************************************************************
  // snapshot handshake, clk side
  // ********************************************************************
  assign ack_s = ack_sync[`KRFEC_SYNC_STAGES-1];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ack_sync <= '0;
      write_en <= '0;
      snap_q   <= '0;
    end else begin
      ack_sync <= {ack_sync[`KRFEC_SYNC_STAGES-2:0], write_en_ack};
      if (write_en == '0 && ack_s == '0) begin
        snap_q   <= counts;               // rx side holds this while idle
        write_en <= '1;                   // request the next capture
      end else if (&ack_s) begin
        write_en <= '0;
      end
    end
  end

  // bus master never issues both strobes together
  a_rd_wr_excl : assert property (@(posedge clk) disable iff (reset)
    !(req.read && req.write));

  // all handshake bits move as one
  a_we_uniform : assert property (@(posedge clk) disable iff (reset)
    (write_en == '0) || (&write_en));

endmodule

// ==== logic/krfec_status_sync.sv ====
// rx_clk side of the count snapshot handshake and the clear crossing
// clear pulses must be spaced by more than the synchronizer latency

`include "krfec_defines.svh"

module krfec_status_sync import krfec_pkg::*; (
  input  logic                       rx_clk,
  input  logic                       reset,
  input  logic [`KRFEC_ACK_BITS-1:0] write_en,       // from clk domain
  input  fec_counts_t                live_counts,
  input  fec_clears_t                clears_clk,     // clk domain pulses
  input  logic                       clk,
  output logic [`KRFEC_ACK_BITS-1:0] write_en_ack,
  output fec_counts_t                held_counts,
  output fec_clears_t                clears_rx
);

  logic [`KRFEC_SYNC_STAGES-1:0][`KRFEC_ACK_BITS-1:0] we_sync;
  logic [`KRFEC_ACK_BITS-1:0] we_s;
  logic                       captured_q;             // held_counts valid for this round
  logic [2:0]                 clr_d;                  // clk side edge detect
  logic [2:0]                 clr_tgl;
  logic [`KRFEC_SYNC_STAGES-1:0][2:0] tgl_sync;
  logic [2:0]                 tgl_last;

  // ********************************************************************
  // snapshot capture and ack
  // ********************************************************************
  assign we_s = we_sync[`KRFEC_SYNC_STAGES-1];

  always_ff @(posedge rx_clk or posedge reset) begin
    if (reset) begin
      we_sync      <= '0;
      captured_q   <= 1'b0;
      write_en_ack <= '0;
    end else begin
      we_sync      <= {we_sync[`KRFEC_SYNC_STAGES-2:0], write_en};
      write_en_ack <= we_s & {`KRFEC_ACK_BITS{captured_q}};  // ack only after capture
      if (&we_s && !captured_q)
        captured_q <= 1'b1;
      else if (we_s == '0)
        captured_q <= 1'b0;                             // round done, rearm
    end
  end

  // payload copy
  always_ff @(posedge rx_clk) begin
    if (&we_s && !captured_q)
      held_counts <= live_counts;
  end

  // ********************************************************************
  // clear pulses, pulse to toggle in clk, toggle to pulse in rx_clk
  // ********************************************************************
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      clr_d   <= '0;
      clr_tgl <= '0;
    end else begin
      clr_d   <= clears_clk;
      clr_tgl <= clr_tgl ^ (clears_clk & ~clr_d);        // flip on rising edge
    end
  end

  always_ff @(posedge rx_clk or posedge reset) begin
    if (reset) begin
      tgl_sync <= '0;
      tgl_last <= '0;
    end else begin
      tgl_sync <= {tgl_sync[`KRFEC_SYNC_STAGES-2:0], clr_tgl};
      tgl_last <= tgl_sync[`KRFEC_SYNC_STAGES-1];
    end
  end

  assign clears_rx = tgl_sync[`KRFEC_SYNC_STAGES-1] ^ tgl_last;  // one rx_clk pulse

  // clk side may sample held_counts at any time the ack is up
  a_held_stable : assert property (@(posedge rx_clk) disable iff (reset)
    (write_en_ack != '0) |=> $stable(held_counts));

endmodule

// ==== logic/krfec_top.sv ====
// KR FEC control and status, bus in clk, block events in rx_clk
// ctrl is quasi static and crosses to the FEC without synchronizers

`include "krfec_defines.svh"

module krfec_top import krfec_pkg::*; (
  input  logic        clk,
  input  logic        rx_clk,
  input  logic        reset,
  input  avmm_req_t   req,
  input  logic        corr_event,   // rx_clk pulses
  input  logic        uncr_event,
  output logic [31:0] readdata,
  output fec_ctrl_t   ctrl
);

  fec_counts_t                live_counts;   // running, rx_clk
  fec_counts_t                held_counts;   // frozen for the clk side
  fec_clears_t                clears_clk;
  fec_clears_t                clears_rx;
  logic [`KRFEC_ACK_BITS-1:0] write_en;
  logic [`KRFEC_ACK_BITS-1:0] write_en_ack;

  krfec_csr krfec_csr_i (
    .clk          (clk),
    .reset        (reset),
    .req          (req),
    .counts       (held_counts),
    .write_en_ack (write_en_ack),
    .readdata     (readdata),
    .ctrl         (ctrl),
    .clears       (clears_clk),
    .write_en     (write_en)
  );

  krfec_status_sync krfec_status_sync_i (
    .rx_clk       (rx_clk),
    .reset        (reset),
    .write_en     (write_en),
    .live_counts  (live_counts),
    .clears_clk   (clears_clk),
    .clk          (clk),
    .write_en_ack (write_en_ack),
    .held_counts  (held_counts),
    .clears_rx    (clears_rx)
  );

  // corrected blocks
  fec_block_counter corr_cnt_i (
    .rx_clk   (rx_clk),
    .reset    (reset),
    .event_in (corr_event),
    .clear    (clears_rx.clear_counters | clears_rx.clr_corr_blks),
    .count    (live_counts.corr_blks)
  );

  // uncorrected blocks
  fec_block_counter uncr_cnt_i (
    .rx_clk   (rx_clk),
    .reset    (reset),
    .event_in (uncr_event),
    .clear    (clears_rx.clear_counters | clears_rx.clr_uncr_blks),
    .count    (live_counts.uncr_blks)
  );

endmodule

// ==== testbench/krfec_checker.sv ====
// compares readdata and ctrl with the expectations sent by the driver
// a read expectation arrives together with its read strobe, readdata is checked one clk later

`include "krfec_defines.svh"

module krfec_checker import krfec_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  avmm_req_t   req,
  input  logic [31:0] readdata,
  input  fec_ctrl_t   ctrl,
  input  logic        exp_valid,     // one cycle, from the driver
  input  logic        exp_is_ctrl,   // 1 ctrl check, 0 read check
  input  int          exp_test,
  input  logic [31:0] exp_value,
  output int          pass_count,
  output int          fail_count
);
  timeunit 1ns;
  timeprecision 1ps;

  logic        rd_pend;                // read seen last cycle, compare now
  logic [31:0] rd_exp;
  logic [7:0]  rd_addr;
  int          rd_test;

  function automatic string reg_name(input logic [7:0] addr);
    case (addr)
      `KRFEC_ADDR_STATUS:  return "status";
      `KRFEC_ADDR_CRRBLKS: return "crrblks";
      `KRFEC_ADDR_UNCBLKS: return "uncblks";
      default:             return "unmapped";
    endcase
  endfunction

  // ********************************************************************
  // compare and report
  // ********************************************************************
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_pend    <= 1'b0;
      rd_exp     <= '0;
      rd_addr    <= '0;
      rd_test    <= 0;
      pass_count <= 0;
      fail_count <= 0;
    end else begin
      rd_pend <= exp_valid && !exp_is_ctrl && req.read;
      rd_exp  <= exp_value;
      rd_addr <= req.address;
      rd_test <= exp_test;
      if (rd_pend) begin
        if (readdata === rd_exp) begin
          $display("test %0d read %h %0s ok, readdata %h", rd_test, rd_addr,
                   reg_name(rd_addr), readdata);
          pass_count <= pass_count + 1;
        end else begin
          $display("error %0d ns test %0d read %h %0s expected %h seen %h", $time,
                   rd_test, rd_addr, reg_name(rd_addr), rd_exp, readdata);
          fail_count <= fail_count + 1;
        end
      end
      if (exp_valid && exp_is_ctrl) begin  // ctrl as it stands after the last edge
        if (ctrl === exp_value[11:0]) begin
          $display("test %0d ctrl ok, ctrl %h", exp_test, ctrl);
          pass_count <= pass_count + 1;
        end else begin
          $display("error %0d ns test %0d ctrl expected %h seen %h", $time, exp_test,
                   exp_value[11:0], ctrl);
          fail_count <= fail_count + 1;
        end
      end
    end
  end

endmodule

// ==== testbench/krfec_tb.sv ====
// testbench for krfec_top, commands and expected values come from testbench/krfec_tests.txt
// run from the project root so that the data file path resolves
// counter reads in the data file must follow enough idle cycles for the snapshot to settle

module krfec_tb import krfec_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_NS = 4;             // clk period, rx_clk runs at 6 ns

  logic        clk;
  logic        rx_clk;
  logic        reset;
  avmm_req_t   req;
  logic        corr_event;
  logic        uncr_event;
  logic [31:0] readdata;
  fec_ctrl_t   ctrl;

  // expectation port towards the checker
  logic        exp_valid;
  logic        exp_is_ctrl;
  int          exp_test;
  logic [31:0] exp_value;
  int          pass_count;
  int          fail_count;

  integer      seed = 30383;
  int          test_num = 0;             // one per R or K command
  int          stim_errors = 0;          // bad lines in the data file
  int          n_lines = 0;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    rx_clk = 1'b0;
    forever #3 rx_clk = ~rx_clk;
  end

  krfec_top krfec_top_i (
    .clk        (clk),
    .rx_clk     (rx_clk),
    .reset      (reset),
    .req        (req),
    .corr_event (corr_event),
    .uncr_event (uncr_event),
    .readdata   (readdata),
    .ctrl       (ctrl)
  );

  krfec_checker krfec_checker_i (
    .clk         (clk),
    .reset       (reset),
    .req         (req),
    .readdata    (readdata),
    .ctrl        (ctrl),
    .exp_valid   (exp_valid),
    .exp_is_ctrl (exp_is_ctrl),
    .exp_test    (exp_test),
    .exp_value   (exp_value),
    .pass_count  (pass_count),
    .fail_count  (fail_count)
  );

  // ********************************************************************
  // bus and event drivers
  // ********************************************************************
  task automatic do_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk);
    req.address   <= addr;
    req.read      <= 1'b0;
    req.write     <= 1'b1;
    req.writedata <= data;
    @(posedge clk);
    req <= '0;                           // single cycle strobe
  endtask

  task automatic do_read(input logic [7:0] addr, input logic [31:0] expected);
    test_num++;
    @(posedge clk);
    req.address <= addr;
    req.read    <= 1'b1;
    req.write   <= 1'b0;
    exp_valid   <= 1'b1;                 // expectation rides with the strobe
    exp_is_ctrl <= 1'b0;
    exp_test    <= test_num;
    exp_value   <= expected;
    @(posedge clk);
    req       <= '0;
    exp_valid <= 1'b0;
  endtask

  task automatic expect_ctrl(input logic [31:0] value);
    test_num++;
    @(posedge clk);
    exp_valid   <= 1'b1;
    exp_is_ctrl <= 1'b1;
    exp_test    <= test_num;
    exp_value   <= value;
    @(posedge clk);
    exp_valid <= 1'b0;
  endtask

  // n single cycle pulses on rx_clk, random gaps of 0 to 3 cycles
  task automatic pulse_events(input logic uncr, input int n);
    int gap;
    for (int i = 0; i < n; i++) begin
      @(posedge rx_clk);
      if (uncr)
        uncr_event <= 1'b1;
      else
        corr_event <= 1'b1;
      @(posedge rx_clk);
      corr_event <= 1'b0;
      uncr_event <= 1'b0;
      gap = $unsigned($random(seed)) % 4;
      repeat (gap) @(posedge rx_clk);
    end
  endtask

  // data file line whose arguments could not be read
  task automatic flag_bad_args(input logic [63:0] cmd);
    $display("missing or unreadable arguments after command %0s in the test file", cmd);
    stim_errors++;
  endtask

  // ********************************************************************
  // command loop
  // ********************************************************************
  initial begin
    int                fd;
    int                code;
    int                n;
    logic [63:0]       tok;
    logic [31:0]       a;
    logic [31:0]       b;
    logic [8*256-1:0]  line_buf;
    reset       = 1'b1;
    req         = '0;
    corr_event  = 1'b0;
    uncr_event  = 1'b0;
    exp_valid   = 1'b0;
    exp_is_ctrl = 1'b0;
    exp_test    = 0;
    exp_value   = '0;
    fd = $fopen("testbench/krfec_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open testbench/krfec_tests.txt");
      $display("=== FAIL ===");
      $finish;
    end else begin
      n = 0;                             // first pass sizes the watchdog
      while ($fgets(line_buf, fd) != 0)
        n++;
      $fclose(fd);
      n_lines = n;
      fd = $fopen("testbench/krfec_tests.txt", "r");
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      while ($fscanf(fd, "%s", tok) == 1) begin
        case (tok)
          "#": code = $fgets(line_buf, fd);  // comment, skip rest of line
          "W": begin
            code = $fscanf(fd, "%h %h", a, b);
            if (code != 2)
              flag_bad_args(tok);
            else
              do_write(a[7:0], b);
          end
          "R": begin
            code = $fscanf(fd, "%h %h", a, b);
            if (code != 2)
              flag_bad_args(tok);
            else
              do_read(a[7:0], b);
          end
          "K": begin
            code = $fscanf(fd, "%h", a);
            if (code != 1)
              flag_bad_args(tok);
            else
              expect_ctrl(a);
          end
          "C": begin
            code = $fscanf(fd, "%d", n);
            if (code != 1)
              flag_bad_args(tok);
            else
              pulse_events(1'b0, n);
          end
          "U": begin
            code = $fscanf(fd, "%d", n);
            if (code != 1)
              flag_bad_args(tok);
            else
              pulse_events(1'b1, n);
          end
          "I": begin
            code = $fscanf(fd, "%d", n);
            if (code != 1)
              flag_bad_args(tok);
            else
              repeat (n) @(posedge clk);
          end
          default: begin
            $display("unknown command %0s in the test file", tok);
            stim_errors++;
            code = $fgets(line_buf, fd);
          end
        endcase
      end
      $fclose(fd);
      repeat (4) @(posedge clk);         // let the last compare land
      $display("tests %0d passed %0d failed %0d bad lines %0d",
               test_num, pass_count, fail_count, stim_errors);
      if (fail_count == 0 && stim_errors == 0 && test_num > 0 && pass_count == test_num)
        $display("=== PASS ===");
      else
        $display("=== FAIL ===");
      $finish;
    end
  end

  // watchdog, 200 clk periods per data file line plus slack
  initial begin
    wait (n_lines > 0);
    #(n_lines * 200 * CLK_NS + 1000);
    $display("timeout, the test file did not finish within %0d ns",
             n_lines * 200 * CLK_NS + 1000);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// ==== testbench/krfec_tests.txt ====
# W addr data | R addr readdata | K ctrl, all hex
# C n corrected events | U n uncorrected events | I n idle clk cycles, all decimal
K 580
R b2 00000580
R b0 00000000
I 80
R b3 00000000
I 30
W b2 000009a5
K 1a5
R b2 000001a5
W b2 fffff123
K 123
R b2 00000123
W b2 00000580
K 580
C 5
I 80
R b3 00000005
I 30
U 7
I 80
R b4 00000007
I 80
R b3 00000000
I 30
C 3
I 80
R b3 00000003
I 30
C 100
U 60
C 50
U 30
I 80
R b3 00000096
I 80
R b4 00000000
I 30
U 40
C 20
U 25
I 80
R b4 00000041
I 80
R b3 00000000
R b0 00000000

// ==== verilog.f ====
+incdir+logic
logic/krfec_pkg.sv
logic/fec_block_counter.sv
logic/krfec_csr.sv
logic/krfec_status_sync.sv
logic/krfec_top.sv
testbench/krfec_checker.sv
testbench/krfec_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the krfec testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module krfec_tb -Mdir obj_dir -o krfec_sim

out=$(./obj_dir/krfec_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "=== PASS ==="; then
  exit 0
fi
exit 1
